/* verilog/ahbPkg.sv */
// AHB side types only; addresses and data are fixed 32-bit words, Hsize is not modelled
package ahbPkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;

	// Byte address as seen on Haddr
	typedef logic [addrWidth-1:0] ahbAddr;

	// One full word on Hwdata or Hrdata
	typedef logic [dataWidth-1:0] ahbData;

	// Htrans encodings from the AHB specification
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} ahbTrans;

	// Address and data history kept by the slave interface.
	// Stage 1 holds the previous cycle, stage 2 the one before that
	typedef struct packed
	{
		ahbAddr addr1;
		ahbAddr addr2;
		ahbData wdata1;
		ahbData wdata2;
		// Direction of the last accepted transfer
		logic writeReg;
	} ahbPipe;

endpackage

/* verilog/apbPkg.sv */
// APB side types and the fixed three-window address map; needs ahbPkg compiled first
package apbPkg;

	// One-hot peripheral select, bit i picks peripheral i
	typedef logic [2:0] apbSel;

	typedef struct packed
	{
		ahbPkg::ahbAddr Paddr;
		ahbPkg::ahbData Pwdata;
		logic Pwrite;
		apbSel Pselx;
		logic Penable;
	} apbReq;

	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenableP = 3'b111
	} apbState;

	localparam ahbPkg::ahbAddr periph0Base = 32'h8000_0000;
	localparam ahbPkg::ahbAddr periph1Base = 32'h8400_0000;
	localparam ahbPkg::ahbAddr periph2Base = 32'h8800_0000;
	localparam ahbPkg::ahbAddr periphSpan  = 32'h0400_0000;

	// Zero when the address lies outside every window
	function automatic apbSel decodeSel(ahbPkg::ahbAddr addr);
		apbSel sel;
		sel[0] = (addr >= periph0Base) && (addr < periph0Base + periphSpan);
		sel[1] = (addr >= periph1Base) && (addr < periph1Base + periphSpan);
		sel[2] = (addr >= periph2Base) && (addr < periph2Base + periphSpan);
		return sel;
	endfunction

endpackage

/* verilog/ahbSlaveInterface.sv */
// Hreadyin must be the bus HREADY (fed back from Hreadyout); transfers outside the map are ignored
`timescale 1ns/1ps

module ahbSlaveInterface
(
	input logic Hclk,
	input logic Hresetn,
	input ahbPkg::ahbAddr Haddr,
	input ahbPkg::ahbData Hwdata,
	input logic Hwrite,
	input ahbPkg::ahbTrans Htrans,
	input logic Hreadyin,
	output logic valid,
	output apbPkg::apbSel tempSelx,
	output ahbPkg::ahbPipe pipe
);

	logic activeTrans;
	logic accepted;

	// BUSY and IDLE carry no transfer
	assign activeTrans = (Htrans == ahbPkg::NONSEQ) || (Htrans == ahbPkg::SEQ);

	// The address phase completes on this edge only when the bus is ready
	assign accepted = Hreadyin && activeTrans;

	// Select is decoded from the live address phase
	assign tempSelx = apbPkg::decodeSel(Haddr);

	assign valid = accepted && (tempSelx != '0);

	// Address and data stages shift every cycle. A stalled master holds its
	// address phase, so addr2 still names the transfer accepted two edges back
	// when the controller leaves a pipelined enable phase
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			pipe <= '0;
		end
		else
		begin
			pipe.addr1 <= Haddr;
			pipe.addr2 <= pipe.addr1;
			pipe.wdata1 <= Hwdata;
			pipe.wdata2 <= pipe.wdata1;
			// Direction only moves with an accepted transfer
			if (valid)
				pipe.writeReg <= Hwrite;
		end
	end

	// Windows must not overlap, otherwise two peripherals answer one transfer
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		valid |-> $onehot(tempSelx));

endmodule

/* verilog/apbFsmController.sv */
// Needs Hreadyin tied to Hreadyout; a read behind a write also holds Hreadyout low in its enable
`timescale 1ns/1ps

module apbFsmController
(
	input logic Hclk,
	input logic Hresetn,
	input logic valid,
	input ahbPkg::ahbAddr Haddr,
	input ahbPkg::ahbData Hwdata,
	input logic Hwrite,
	input ahbPkg::ahbPipe pipe,
	input apbPkg::apbSel tempSelx,
	output apbPkg::apbReq apb,
	output logic Hreadyout
);

	apbPkg::apbState state;
	apbPkg::apbState nextState;
	apbPkg::apbReq nextApb;
	logic nextReady;

	// Request word for the first cycle of an APB transfer
	function automatic apbPkg::apbReq setupReq
	(
		ahbPkg::ahbAddr addr,
		ahbPkg::ahbData data,
		logic write,
		apbPkg::apbSel sel
	);
		return '{Paddr: addr, Pwdata: data, Pwrite: write, Pselx: sel, Penable: 1'b0};
	endfunction

	function automatic logic legalStep(apbPkg::apbState prev, apbPkg::apbState cur);
		case (cur)
			apbPkg::stIdle, apbPkg::stWwait:
				return prev inside {apbPkg::stIdle, apbPkg::stRenable, apbPkg::stWenable};
			apbPkg::stRead:
				return prev inside {apbPkg::stIdle, apbPkg::stRenable, apbPkg::stWenable,
					apbPkg::stWenableP};
			apbPkg::stWrite, apbPkg::stWriteP:
				return prev inside {apbPkg::stWwait, apbPkg::stWenableP};
			apbPkg::stRenable:
				return prev == apbPkg::stRead;
			apbPkg::stWenable:
				return prev == apbPkg::stWrite;
			default:
				return prev == apbPkg::stWriteP;
		endcase
	endfunction

	// Next state and the outputs that go with it are decoded together, so
	// every output below appears one register stage after the decision
	always_comb
	begin
		nextState = apbPkg::stIdle;
		nextApb = apb;
		nextApb.Pselx = '0;
		nextApb.Penable = 1'b0;
		nextReady = 1'b1;
		case (state)
			apbPkg::stIdle, apbPkg::stRenable, apbPkg::stWenable:
			begin
				if (valid && Hwrite)
				begin
					// Write data is not on the bus yet, let the data phase finish
					nextState = apbPkg::stWwait;
				end
				else if (valid)
				begin
					// A read goes straight out from the current address phase
					nextState = apbPkg::stRead;
					nextApb = setupReq(Haddr, apb.Pwdata, 1'b0, tempSelx);
					nextReady = 1'b0;
				end
			end
			apbPkg::stWwait:
			begin
				// Hwdata belongs to the write in addr1; a new address phase may land now
				nextState = valid ? apbPkg::stWriteP : apbPkg::stWrite;
				nextApb = setupReq(pipe.addr1, Hwdata, 1'b1, apbPkg::decodeSel(pipe.addr1));
				nextReady = 1'b0;
			end
			apbPkg::stRead:
			begin
				nextState = apbPkg::stRenable;
				nextApb.Pselx = apb.Pselx;
				nextApb.Penable = 1'b1;
			end
			apbPkg::stWrite:
			begin
				nextState = apbPkg::stWenable;
				nextApb.Pselx = apb.Pselx;
				nextApb.Penable = 1'b1;
			end
			apbPkg::stWriteP:
			begin
				nextState = apbPkg::stWenableP;
				nextApb.Pselx = apb.Pselx;
				nextApb.Penable = 1'b1;
				// A pending read must not see its data phase end before its own enable
				nextReady = pipe.writeReg;
			end
			apbPkg::stWenableP:
			begin
				if (pipe.writeReg)
				begin
					nextState = valid ? apbPkg::stWriteP : apbPkg::stWrite;
					nextApb = setupReq(pipe.addr2, Hwdata, 1'b1,
						apbPkg::decodeSel(pipe.addr2));
				end
				else
				begin
					nextState = apbPkg::stRead;
					nextApb = setupReq(pipe.addr2, apb.Pwdata, 1'b0,
						apbPkg::decodeSel(pipe.addr2));
				end
				nextReady = 1'b0;
			end
			default:
			begin
				nextState = apbPkg::stIdle;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		apb.Paddr <= nextApb.Paddr;
		apb.Pwdata <= nextApb.Pwdata;
		if (!Hresetn)
		begin
			state <= apbPkg::stIdle;
			apb.Pwrite <= 1'b0;
			apb.Pselx <= '0;
			apb.Penable <= 1'b0;
			Hreadyout <= 1'b1;
		end
		else
		begin
			state <= nextState;
			apb.Pwrite <= nextApb.Pwrite;
			apb.Pselx <= nextApb.Pselx;
			apb.Penable <= nextApb.Penable;
			Hreadyout <= nextReady;
		end
	end

	// Enable only ever follows a one-cycle setup to the same peripheral
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		$rose(apb.Penable) |-> ($past(apb.Pselx) != '0) && $stable(apb.Pselx));

	// Setup lasts one cycle and the request does not move into the enable phase
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		(apb.Pselx != '0) && !apb.Penable |=>
			apb.Penable && $stable(apb.Paddr) && $stable(apb.Pwrite));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		legalStep($past(state), state));

endmodule

/* verilog/ahbApbBridgeTop.sv */
// AHB and APB share Hclk; no Pready, no error response, word transfers only, Hreadyin = Hreadyout
`timescale 1ns/1ps

module ahbApbBridgeTop
(
	input logic Hclk,
	input logic Hresetn,
	input ahbPkg::ahbAddr Haddr,
	input ahbPkg::ahbData Hwdata,
	input logic Hwrite,
	input ahbPkg::ahbTrans Htrans,
	input logic Hreadyin,
	output logic Hreadyout,
	output ahbPkg::ahbData Hrdata,
	output apbPkg::apbReq apb,
	input ahbPkg::ahbData Prdata
);

	logic valid;
	apbPkg::apbSel tempSelx;
	ahbPkg::ahbPipe pipe;

	ahbSlaveInterface ahbSlaveInterface_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Htrans(Htrans),
		.Hreadyin(Hreadyin),
		.valid(valid),
		.tempSelx(tempSelx),
		.pipe(pipe)
	);

	apbFsmController apbFsmController_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.pipe(pipe),
		.tempSelx(tempSelx),
		.apb(apb),
		.Hreadyout(Hreadyout)
	);

	// Read data is valid in the enable cycle, when Hreadyout is high
	assign Hrdata = Prdata;

endmodule

/* tb/apbPeripheralModel.sv */
// Three APB peripherals without wait states; read data follows a fixed rule, only the last write is kept
`timescale 1ns/1ps

module apbPeripheralModel
(
	input logic Hclk,
	input logic Hresetn,
	input apbPkg::apbReq apb,
	output ahbPkg::ahbData Prdata,
	output ahbPkg::ahbAddr lastAddr,
	output ahbPkg::ahbData lastData
);

	logic [1:0] index;

	// Index of the selected peripheral, taken from the one-hot select
	always_comb
	begin
		case (apb.Pselx)
			3'b010: index = 2'd1;
			3'b100: index = 2'd2;
			default: index = 2'd0;
		endcase
	end

	// Each peripheral answers with the inverted address mixed with its own index
	assign Prdata = ~apb.Paddr ^ {30'b0, index};

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			lastAddr <= '0;
			lastData <= '0;
		end
		else if (apb.Penable && apb.Pwrite && (apb.Pselx != '0))
		begin
			// The write takes effect in its enable phase
			lastAddr <= apb.Paddr;
			lastData <= apb.Pwdata;
		end
	end

endmodule

/* tb/ahbApbBridgeTb.sv */
// Hreadyin is driven as the bus HREADY from Hreadyout; probes run on an idle bridge
`timescale 1ns/1ps

module ahbApbBridgeTb;

	typedef struct packed
	{
		ahbPkg::ahbAddr addr;
		ahbPkg::ahbData wdata;
		logic write;
	} xfer;

	localparam int resetCycles = 16;
	localparam int streamCount = 3;
	localparam int streamLen = 8;
	localparam int plannedTransfers = 5 + 2 + streamCount * streamLen;
	localparam int cycleLimit = resetCycles + 40 * plannedTransfers;

	logic Hclk;
	logic Hresetn;
	ahbPkg::ahbAddr Haddr;
	ahbPkg::ahbData Hwdata;
	logic Hwrite;
	ahbPkg::ahbTrans Htrans;
	logic Hreadyin;
	logic Hreadyout;
	ahbPkg::ahbData Hrdata;
	apbPkg::apbReq apb;
	ahbPkg::ahbData Prdata;
	ahbPkg::ahbAddr logAddr;
	ahbPkg::ahbData logData;
	logic setupCycle;

	// Master and scoreboard state
	xfer issueQ[$];
	xfer expectQ[$];
	xfer curXfer;
	xfer dataXfer;
	xfer expHead;
	xfer lastWrite;
	logic haveAddr;
	logic readyPrev;
	logic enablePrev;
	logic expValid;
	logic anyAccepted;
	logic writeLogged;
	apbPkg::apbSel expSel;
	ahbPkg::ahbData expRdata;
	int cycleCount = 0;

	ahbApbBridgeTop ahbApbBridgeTop_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hwrite(Hwrite),
		.Htrans(Htrans),
		.Hreadyin(Hreadyin),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.apb(apb),
		.Prdata(Prdata)
	);

	apbPeripheralModel apbPeripheralModel_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.apb(apb),
		.Prdata(Prdata),
		.lastAddr(logAddr),
		.lastData(logData)
	);

	assign setupCycle = (apb.Pselx != '0) && !apb.Penable;

	task automatic stopWithFailure(string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(string signalName, logic [31:0] expVal, logic [31:0] actVal);
		stopWithFailure($sformatf("MISMATCH at %0t ns: %s expected %h actual %h",
			$time, signalName, expVal, actVal));
	endtask

	function automatic int windowIndex(ahbPkg::ahbAddr addr);
		return (addr - apbPkg::periph0Base) / apbPkg::periphSpan;
	endfunction

	// Word address somewhere inside one of the three windows
	function automatic ahbPkg::ahbAddr randomAddr();
		ahbPkg::ahbAddr offset;
		offset = $urandom & (apbPkg::periphSpan - 1) & ~32'h3;
		return apbPkg::periph0Base + apbPkg::periphSpan * ($urandom % 3) + offset;
	endfunction

	function automatic xfer makeXfer(logic write);
		xfer t;
		t.addr = randomAddr();
		t.wdata = $urandom;
		t.write = write;
		return t;
	endfunction

	// One bus cycle of the pipelined master plus scoreboard upkeep
	task automatic masterCycle();
		xfer done;
		@(negedge Hclk);
		if (enablePrev)
		begin
			done = expectQ.pop_front();
			if (done.write)
			begin
				lastWrite = done;
				writeLogged = 1'b1;
			end
		end
		enablePrev = apb.Penable;
		// Address and data phases only move on when HREADY was high at the last edge
		if (readyPrev)
		begin
			dataXfer = curXfer;
			haveAddr = issueQ.size() != 0;
			if (haveAddr)
				curXfer = issueQ.pop_front();
		end
		Htrans = haveAddr ? ahbPkg::NONSEQ : ahbPkg::IDLE;
		Haddr = curXfer.addr;
		Hwrite = curXfer.write;
		Hwdata = dataXfer.wdata;
		Hreadyin = Hreadyout;
		readyPrev = Hreadyin;
		if (haveAddr && readyPrev)
		begin
			expectQ.push_back(curXfer);
			anyAccepted = 1'b1;
		end
		expValid = expectQ.size() != 0;
		if (expValid)
		begin
			expHead = expectQ[0];
			expSel = 3'b001 << windowIndex(expHead.addr);
			expRdata = ~expHead.addr ^ ahbPkg::ahbData'(windowIndex(expHead.addr));
		end
	endtask

	// Drives a cycle pattern that must not start any transfer
	task automatic probe(ahbPkg::ahbTrans trans, ahbPkg::ahbAddr addr, logic readyMask);
		repeat (3)
		begin
			@(negedge Hclk);
			Htrans = trans;
			Haddr = addr;
			Hwrite = $urandom % 2;
			Hwdata = $urandom;
			Hreadyin = Hreadyout && readyMask;
			readyPrev = Hreadyin;
		end
	endtask

	task automatic drain();
		while ((issueQ.size() != 0) || (expectQ.size() != 0) || haveAddr)
			masterCycle();
		repeat (2)
			masterCycle();
	endtask

	initial
	begin
		Hclk = 1'b0;
		forever #20 Hclk = ~Hclk;
	end

	always @(posedge Hclk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			stopWithFailure($sformatf("Timeout after %0d cycles, transfers stopped completing",
				cycleCount));
	end

	initial
	begin
		void'($urandom(32'hd131_ebb3));
		Hresetn = 1'b0;
		Haddr = '0;
		Hwdata = '0;
		Hwrite = 1'b0;
		Htrans = ahbPkg::IDLE;
		Hreadyin = 1'b1;
		curXfer = '0;
		dataXfer = '0;
		expHead = '0;
		lastWrite = '0;
		haveAddr = 1'b0;
		readyPrev = 1'b1;
		enablePrev = 1'b0;
		expValid = 1'b0;
		anyAccepted = 1'b0;
		writeLogged = 1'b0;
		expSel = '0;
		expRdata = '0;
		repeat (resetCycles)
			@(negedge Hclk);
		Hresetn = 1'b1;
		probe(ahbPkg::IDLE, randomAddr(), 1'b1);
		probe(ahbPkg::BUSY, randomAddr(), 1'b1);
		probe(ahbPkg::NONSEQ, randomAddr(), 1'b0);
		probe(ahbPkg::NONSEQ, apbPkg::periph2Base + apbPkg::periphSpan, 1'b1);
		probe(ahbPkg::NONSEQ, apbPkg::periph0Base - 32'h4, 1'b1);
		issueQ.push_back(makeXfer(1'b0));
		drain();
		issueQ.push_back(makeXfer(1'b1));
		drain();
		// Mostly writes back to back, every stream closed by a read
		repeat (streamCount)
		begin
			for (int i = 0; i < streamLen - 1; i++)
				issueQ.push_back(makeXfer(($urandom % 4) != 0));
			issueQ.push_back(makeXfer(1'b0));
			drain();
		end
		$display("TEST PASSED");
		$finish;
	end

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		!anyAccepted |-> (apb.Pselx == '0) && !apb.Penable && Hreadyout)
		else stopWithFailure("Bridge left its reset state before any transfer was accepted");

	assert property (@(posedge Hclk) disable iff (!Hresetn) (apb.Pselx != '0) |-> expValid)
		else stopWithFailure("APB select raised with no accepted AHB transfer pending");

	assert property (@(posedge Hclk) disable iff (!Hresetn) apb.Penable |-> apb.Pselx == expSel)
		else reportMismatch("Pselx", expSel, $sampled(apb.Pselx));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.Penable |-> apb.Paddr == expHead.addr)
		else reportMismatch("Paddr", expHead.addr, $sampled(apb.Paddr));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.Penable |-> apb.Pwrite == expHead.write)
		else reportMismatch("Pwrite", expHead.write, $sampled(apb.Pwrite));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.Penable && apb.Pwrite |-> apb.Pwdata == expHead.wdata)
		else reportMismatch("Pwdata", expHead.wdata, $sampled(apb.Pwdata));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.Penable && !apb.Pwrite |-> Hrdata == expRdata)
		else reportMismatch("Hrdata", expRdata, $sampled(Hrdata));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeLogged |-> logAddr == lastWrite.addr)
		else reportMismatch("lastAddr", lastWrite.addr, $sampled(logAddr));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		writeLogged |-> logData == lastWrite.wdata)
		else reportMismatch("lastData", lastWrite.wdata, $sampled(logData));

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		setupCycle |=> apb.Penable && $stable(apb.Pselx) && $stable(apb.Paddr) &&
			$stable(apb.Pwrite) && $stable(apb.Pwdata))
		else stopWithFailure("APB setup phase not followed by a matching enable phase");

	assert property (@(posedge Hclk) disable iff (!Hresetn) apb.Penable |-> $past(setupCycle))
		else stopWithFailure("APB enable phase without a setup cycle before it");

	assert property (@(posedge Hclk) disable iff (!Hresetn) apb.Penable |=> !apb.Penable)
		else stopWithFailure("APB enable phase lasted more than one cycle");

	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.Penable && !apb.Pwrite |-> Hreadyout)
		else reportMismatch("Hreadyout", 1, $sampled(Hreadyout));

	// A write enable may only hold the bus when a read setup comes right after it
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		apb.Penable && !Hreadyout |=> setupCycle && !apb.Pwrite)
		else stopWithFailure("Hreadyout low in an enable phase that no read follows");

endmodule

/* filelist.f */
verilog/ahbPkg.sv
verilog/apbPkg.sv
verilog/ahbSlaveInterface.sv
verilog/apbFsmController.sv
verilog/ahbApbBridgeTop.sv
tb/apbPeripheralModel.sv
tb/ahbApbBridgeTb.sv

/* Bender.yml */
package:
  name: ahb_apb_bridge

sources:
  - files:
      - verilog/ahbPkg.sv
      - verilog/apbPkg.sv
      - verilog/ahbSlaveInterface.sv
      - verilog/apbFsmController.sv
      - verilog/ahbApbBridgeTop.sv

  - target: test
    files:
      - tb/apbPeripheralModel.sv
      - tb/ahbApbBridgeTb.sv
